// File: all.f
hw/zbus_pkg.sv
hw/zram.sv
hw/mbus_zbus_port.sv
hw/z80_zbus_port.sv
hw/zbus_arbiter.sv
hw/zbus_top.sv
verification/zbus_tb.sv

// File: hw/mbus_zbus_port.sv
//------------------------------------------------------------
// 68000 side of the Z80 bus
// Bus request / Z80 reset control, bus-free gating of the
// window accesses, byte lane select and DTACK hold
//------------------------------------------------------------
`timescale 1ns/1ps

module mbus_zbus_port
	import zbus_pkg::*;
(
	input  logic               MCLK,
	input  logic               reset,

	input  logic               mbus_sel,
	input  logic [13:0]        mbus_addr,
	input  logic               mbus_uds_n,
	input  logic               mbus_rnw,
	input  logic [15:0]        mbus_wdata,
	output logic [15:0]        mbus_rdata,
	output logic               mbus_dtack_n,

	input  logic               ctrl_we,
	input  logic               ctrl_reg,
	input  logic               ctrl_wdata,
	output logic               z80_busrq_n,
	output logic               z80_reset_n,

	output logic               req,
	output logic [ZADDR_W-1:0] req_addr,
	output logic               req_we,
	output logic [ZDATA_W-1:0] req_wdata,
	input  logic               done,
	input  logic [ZDATA_W-1:0] done_data
);

	logic               bus_free;
	logic [ZDATA_W-1:0] rd_byte;

	//------------------------------------------------------------
	// Control register
	//------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (ctrl_we) begin
			if (ctrl_reg == CTRL_BUSREQ) begin
				z80_busrq_n <= ~ctrl_wdata;
			end
			if (ctrl_reg == CTRL_RESET) begin
				z80_reset_n <= ctrl_wdata;
			end
		end
	end

	// 68000 owns the Z80 bus only while the Z80 is held off and out of reset
	assign bus_free = ~z80_busrq_n & z80_reset_n;

	//------------------------------------------------------------
	// Request toward the arbiter
	//------------------------------------------------------------
	// Even byte sits on the upper lane
	assign req_addr  = {mbus_addr, mbus_uds_n};
	assign req_wdata = mbus_uds_n ? mbus_wdata[7:0] : mbus_wdata[15:8];
	assign req_we    = ~mbus_rnw & bus_free;
	assign req       = mbus_sel & mbus_dtack_n;

	//------------------------------------------------------------
	// Acknowledge and read data hold
	//------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			mbus_dtack_n <= 1'b1;
		end else if (done) begin
			mbus_dtack_n <= 1'b0;
		end else if (!mbus_sel) begin
			mbus_dtack_n <= 1'b1;
		end
	end

	always_ff @(posedge MCLK) begin
		if (done) begin
			rd_byte <= bus_free ? done_data : EMPTY_BYTE;
		end
	end

	// Same byte on both lanes
	assign mbus_rdata = {rd_byte, rd_byte};

endmodule

// File: hw/z80_zbus_port.sv
//------------------------------------------------------------
// Z80 side of the Z80 bus
// Decodes the 0000-7EFF window and holds the acknowledge
//------------------------------------------------------------
`timescale 1ns/1ps

module z80_zbus_port
	import zbus_pkg::*;
(
	input  logic               MCLK,
	input  logic               reset,

	input  logic               z80_sel,
	input  logic [15:0]        z80_addr,
	input  logic               z80_wr,
	input  logic [ZDATA_W-1:0] z80_wdata,
	output logic [ZDATA_W-1:0] z80_rdata,
	output logic               z80_dtack_n,

	output logic               req,
	output logic [ZADDR_W-1:0] req_addr,
	output logic               req_we,
	output logic [ZDATA_W-1:0] req_wdata,
	input  logic               done,
	input  logic [ZDATA_W-1:0] done_data
);

	logic in_window;

	// 7F00 and up belongs to the main bus side
	assign in_window = z80_addr < Z80_WINDOW_END;

	assign req       = z80_sel & in_window & z80_dtack_n;
	assign req_addr  = z80_addr[ZADDR_W-1:0];
	assign req_we    = z80_wr;
	assign req_wdata = z80_wdata;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_dtack_n <= 1'b1;
		end else if (done) begin
			z80_dtack_n <= 1'b0;
		end else if (!z80_sel) begin
			z80_dtack_n <= 1'b1;
		end
	end

	always_ff @(posedge MCLK) begin
		if (done) begin
			z80_rdata <= done_data;
		end
	end

endmodule

// File: hw/zbus_arbiter.sv
//------------------------------------------------------------
// Z80 bus sequencer
// One access at a time, 68000 first, then Z80
// Region decode to work RAM, bank register or empty bus
//------------------------------------------------------------
`timescale 1ns/1ps

module zbus_arbiter
	import zbus_pkg::*;
(
	input  logic               MCLK,
	input  logic               reset,

	input  logic               m_req,
	input  logic [ZADDR_W-1:0] m_addr,
	input  logic               m_we,
	input  logic [ZDATA_W-1:0] m_wdata,
	output logic               m_done,
	output logic [ZDATA_W-1:0] m_rdata,

	input  logic               z_req,
	input  logic [ZADDR_W-1:0] z_addr,
	input  logic               z_we,
	input  logic [ZDATA_W-1:0] z_wdata,
	output logic               z_done,
	output logic [ZDATA_W-1:0] z_rdata,

	output logic [BANK_W-1:0]  bank_addr
);

	zbus_state_t        state;
	logic               src_z80;
	logic [ZADDR_W-1:0] cur_addr;
	logic               cur_we;
	logic [ZDATA_W-1:0] cur_wdata;

	logic               ram_sel;
	logic               bank_sel;
	logic               ram_we;
	logic [ZDATA_W-1:0] ram_rdata;
	logic [ZDATA_W-1:0] rd_data;

	//------------------------------------------------------------
	// Sequencer
	//------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= ZS_IDLE;
		end else begin
			case (state)
				ZS_IDLE: begin
					if (m_req || z_req) begin
						state <= ZS_ACCESS;
					end
				end
				ZS_ACCESS: state <= ZS_FINISH;
				default:   state <= ZS_IDLE;
			endcase
		end
	end

	// Access latch, fixed priority
	always_ff @(posedge MCLK) begin
		if (state == ZS_IDLE) begin
			if (m_req) begin
				src_z80   <= 1'b0;
				cur_addr  <= m_addr;
				cur_we    <= m_we;
				cur_wdata <= m_wdata;
			end else if (z_req) begin
				src_z80   <= 1'b1;
				cur_addr  <= z_addr;
				cur_we    <= z_we;
				cur_wdata <= z_wdata;
			end
		end
	end

	//------------------------------------------------------------
	// Region decode
	//------------------------------------------------------------
	// RAM 0000-3FFF, mirrored every 8 KB
	assign ram_sel  = ~cur_addr[14];
	assign bank_sel = cur_addr[14:8] == BANK_PAGE;
	assign ram_we   = (state == ZS_ACCESS) & cur_we & ram_sel;

	zram u_ram (
		.MCLK  (MCLK),
		.addr  (cur_addr[ZRAM_AW-1:0]),
		.we    (ram_we),
		.wdata (cur_wdata),
		.rdata (ram_rdata)
	);

	// Bank register shifts in from the top, one bit per write
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_addr <= '0;
		end else if (state == ZS_ACCESS && cur_we && bank_sel) begin
			bank_addr <= {cur_wdata[0], bank_addr[BANK_W-1:1]};
		end
	end

	// FM region and bank page read as empty bus
	assign rd_data = ram_sel ? ram_rdata : EMPTY_BYTE;

	assign m_done  = (state == ZS_FINISH) & ~src_z80;
	assign z_done  = (state == ZS_FINISH) & src_z80;
	assign m_rdata = rd_data;
	assign z_rdata = rd_data;

endmodule

// File: hw/zbus_pkg.sv
//------------------------------------------------------------
// Z80 sound bus shared definitions
// Widths, address windows and arbiter state encoding
//------------------------------------------------------------
package zbus_pkg;

	// Bus widths
	localparam int ZADDR_W = 15;
	localparam int ZDATA_W = 8;
	localparam int ZRAM_AW = 13;
	localparam int BANK_W  = 9;

	// Value seen on reads with nothing driving the bus
	localparam logic [ZDATA_W-1:0] EMPTY_BYTE = 8'hFF;

	// Z80 own window is 0000-7EFF
	localparam logic [15:0] Z80_WINDOW_END = 16'h7F00;

	// Address bits 14:8 of the bank register page 6000-60FF
	localparam logic [6:0] BANK_PAGE = 7'h60;

	// Control register selectors
	localparam logic CTRL_BUSREQ = 1'b0;
	localparam logic CTRL_RESET  = 1'b1;

	typedef enum logic [1:0] {
		ZS_IDLE   = 2'd0,
		ZS_ACCESS = 2'd1,
		ZS_FINISH = 2'd2
	} zbus_state_t;

endpackage

// File: hw/zbus_top.sv
//------------------------------------------------------------
// Z80 sound bus top level
// 68000 port and Z80 port sharing one bus through the arbiter
//------------------------------------------------------------
`timescale 1ns/1ps

module zbus_top
	import zbus_pkg::*;
(
	input  logic               MCLK,
	input  logic               reset,

	// 68000 window
	input  logic               mbus_sel,
	input  logic [13:0]        mbus_addr,
	input  logic               mbus_uds_n,
	input  logic               mbus_rnw,
	input  logic [15:0]        mbus_wdata,
	output logic [15:0]        mbus_rdata,
	output logic               mbus_dtack_n,

	// Control register
	input  logic               ctrl_we,
	input  logic               ctrl_reg,
	input  logic               ctrl_wdata,
	output logic               z80_busrq_n,
	output logic               z80_reset_n,

	// Z80 window
	input  logic               z80_sel,
	input  logic [15:0]        z80_addr,
	input  logic               z80_wr,
	input  logic [ZDATA_W-1:0] z80_wdata,
	output logic [ZDATA_W-1:0] z80_rdata,
	output logic               z80_dtack_n,

	output logic [BANK_W-1:0]  bank_addr
);

	logic               m_req;
	logic [ZADDR_W-1:0] m_addr;
	logic               m_we;
	logic [ZDATA_W-1:0] m_wdata;
	logic               m_done;
	logic [ZDATA_W-1:0] m_rdata;

	logic               z_req;
	logic [ZADDR_W-1:0] z_addr;
	logic               z_we;
	logic [ZDATA_W-1:0] z_wdata;
	logic               z_done;
	logic [ZDATA_W-1:0] z_rdata;

	mbus_zbus_port u_mport (
		.MCLK         (MCLK),
		.reset        (reset),
		.mbus_sel     (mbus_sel),
		.mbus_addr    (mbus_addr),
		.mbus_uds_n   (mbus_uds_n),
		.mbus_rnw     (mbus_rnw),
		.mbus_wdata   (mbus_wdata),
		.mbus_rdata   (mbus_rdata),
		.mbus_dtack_n (mbus_dtack_n),
		.ctrl_we      (ctrl_we),
		.ctrl_reg     (ctrl_reg),
		.ctrl_wdata   (ctrl_wdata),
		.z80_busrq_n  (z80_busrq_n),
		.z80_reset_n  (z80_reset_n),
		.req          (m_req),
		.req_addr     (m_addr),
		.req_we       (m_we),
		.req_wdata    (m_wdata),
		.done         (m_done),
		.done_data    (m_rdata)
	);

	z80_zbus_port u_zport (
		.MCLK        (MCLK),
		.reset       (reset),
		.z80_sel     (z80_sel),
		.z80_addr    (z80_addr),
		.z80_wr      (z80_wr),
		.z80_wdata   (z80_wdata),
		.z80_rdata   (z80_rdata),
		.z80_dtack_n (z80_dtack_n),
		.req         (z_req),
		.req_addr    (z_addr),
		.req_we      (z_we),
		.req_wdata   (z_wdata),
		.done        (z_done),
		.done_data   (z_rdata)
	);

	zbus_arbiter u_arb (
		.MCLK      (MCLK),
		.reset     (reset),
		.m_req     (m_req),
		.m_addr    (m_addr),
		.m_we      (m_we),
		.m_wdata   (m_wdata),
		.m_done    (m_done),
		.m_rdata   (m_rdata),
		.z_req     (z_req),
		.z_addr    (z_addr),
		.z_we      (z_we),
		.z_wdata   (z_wdata),
		.z_done    (z_done),
		.z_rdata   (z_rdata),
		.bank_addr (bank_addr)
	);

endmodule

// File: hw/zram.sv
//------------------------------------------------------------
// Z80 work RAM
// 8 KB single port, synchronous read and write
//------------------------------------------------------------
`timescale 1ns/1ps

module zram
	import zbus_pkg::*;
(
	input  logic               MCLK,
	input  logic [ZRAM_AW-1:0] addr,
	input  logic               we,
	input  logic [ZDATA_W-1:0] wdata,
	output logic [ZDATA_W-1:0] rdata
);

	localparam int DEPTH = 1 << ZRAM_AW;

	logic [ZDATA_W-1:0] mem [0:DEPTH-1];

	// Read returns the old contents on a write cycle
	always_ff @(posedge MCLK) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the Z80 sound bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	--top-module zbus_tb -f all.f -o zbus_sim
./obj_dir/zbus_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// File: verification/zbus_tb.sv
//------------------------------------------------------------
// Z80 sound bus testbench
// Replays accesses from the test data file on both ports
// and checks read data, acknowledge timing and bank register
//------------------------------------------------------------
`timescale 1ns/1ps

module zbus_tb
	import zbus_pkg::*;
();

	logic               MCLK;
	logic               reset;
	logic               mbus_sel;
	logic [13:0]        mbus_addr;
	logic               mbus_uds_n;
	logic               mbus_rnw;
	logic [15:0]        mbus_wdata;
	logic [15:0]        mbus_rdata;
	logic               mbus_dtack_n;
	logic               ctrl_we;
	logic               ctrl_reg;
	logic               ctrl_wdata;
	logic               z80_busrq_n;
	logic               z80_reset_n;
	logic               z80_sel;
	logic [15:0]        z80_addr;
	logic               z80_wr;
	logic [ZDATA_W-1:0] z80_wdata;
	logic [ZDATA_W-1:0] z80_rdata;
	logic               z80_dtack_n;
	logic [BANK_W-1:0]  bank_addr;

	// Test steps, one entry per data line
	logic [7:0]  step_src  [$];
	logic [7:0]  step_op   [$];
	logic [15:0] step_addr [$];
	logic [15:0] step_data [$];
	logic [15:0] step_rexp [$];
	logic [15:0] step_bexp [$];

	int   errors = 0;
	int   checks = 0;
	int   seed = 47;
	logic loaded = 1'b0;

	zbus_top u_dut (.*);

	initial begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Cycles from the select edge until the acknowledge is seen low
	task automatic wait_ack_low(input logic z80_side, output int cycles);
		cycles = 0;
		@(negedge MCLK);
		while (z80_side ? z80_dtack_n : mbus_dtack_n) begin
			cycles++;
			@(negedge MCLK);
		end
	endtask

	task automatic release_bus();
		@(posedge MCLK);
		mbus_sel <= 1'b0;
		mbus_rnw <= 1'b1;
		z80_sel  <= 1'b0;
		z80_wr   <= 1'b0;
		@(negedge MCLK);
		while (!mbus_dtack_n || !z80_dtack_n) begin
			@(negedge MCLK);
		end
	endtask

	task automatic drive_mbus(input logic [7:0] op, input logic [15:0] addr,
	                          input logic [15:0] data);
		mbus_sel   <= 1'b1;
		mbus_addr  <= addr[14:1];
		mbus_uds_n <= addr[0];
		mbus_rnw   <= (op == "r");
		// Selected lane carries the byte, the other lane its complement
		mbus_wdata <= addr[0] ? {~data[7:0], data[7:0]} : {data[7:0], ~data[7:0]};
	endtask

	task automatic mbus_access(input logic [7:0] op, input logic [15:0] addr,
	                           input logic [15:0] data, input logic [15:0] rexp);
		int cycles;
		@(posedge MCLK);
		drive_mbus(op, addr, data);
		wait_ack_low(1'b0, cycles);
		check_value("mbus_dtack_n latency", 16'(cycles), 16'd3);
		if (op == "r") begin
			check_value("mbus_rdata", mbus_rdata, {rexp[7:0], rexp[7:0]});
		end
		release_bus();
	endtask

	task automatic z80_access(input logic [7:0] op, input logic [15:0] addr,
	                          input logic [15:0] data, input logic [15:0] rexp);
		int cycles;
		@(posedge MCLK);
		z80_sel   <= 1'b1;
		z80_addr  <= addr;
		z80_wr    <= (op == "w");
		z80_wdata <= data[7:0];
		wait_ack_low(1'b1, cycles);
		check_value("z80_dtack_n latency", 16'(cycles), 16'd3);
		if (op == "r") begin
			check_value("z80_rdata", 16'(z80_rdata), rexp);
		end
		release_bus();
	endtask

	// 68000 access and Z80 read of the same address in the same cycle
	task automatic both_access(input logic [7:0] op, input logic [15:0] addr,
	                           input logic [15:0] data, input logic [15:0] rexp);
		int cycles;
		@(posedge MCLK);
		drive_mbus(op, addr, data);
		z80_sel  <= 1'b1;
		z80_addr <= addr;
		z80_wr   <= 1'b0;
		wait_ack_low(1'b0, cycles);
		check_value("mbus_dtack_n latency", 16'(cycles), 16'd3);
		while (z80_dtack_n) begin
			@(negedge MCLK);
		end
		if (op == "r") begin
			check_value("mbus_rdata", mbus_rdata, {rexp[7:0], rexp[7:0]});
		end
		check_value("z80_rdata", 16'(z80_rdata), rexp);
		release_bus();
	endtask

	task automatic ctrl_write(input logic [15:0] addr, input logic [15:0] data,
	                          input logic [15:0] rexp);
		@(posedge MCLK);
		ctrl_we    <= 1'b1;
		ctrl_reg   <= addr[0];
		ctrl_wdata <= data[0];
		@(posedge MCLK);
		ctrl_we <= 1'b0;
		@(negedge MCLK);
		check_value("{z80_busrq_n,z80_reset_n}", {14'b0, z80_busrq_n, z80_reset_n}, rexp);
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial begin
		int                fd;
		int                gap;
		logic [8*128-1:0]  junk;
		logic [7:0]        src;
		logic [7:0]        op;
		logic [15:0]       addr;
		logic [15:0]       data;
		logic [15:0]       rexp;
		logic [15:0]       bexp;

		reset      = 1'b1;
		mbus_sel   = 1'b0;
		mbus_addr  = '0;
		mbus_uds_n = 1'b0;
		mbus_rnw   = 1'b1;
		mbus_wdata = '0;
		ctrl_we    = 1'b0;
		ctrl_reg   = 1'b0;
		ctrl_wdata = 1'b0;
		z80_sel    = 1'b0;
		z80_addr   = '0;
		z80_wr     = 1'b0;
		z80_wdata  = '0;

		fd = $fopen("verification/zbus_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			errors++;
		end else begin
			// Two column description lines
			void'($fgets(junk, fd));
			void'($fgets(junk, fd));
			while ($fscanf(fd, " %c %c %h %h %h %h", src, op, addr, data, rexp, bexp) == 6) begin
				step_src.push_back(src);
				step_op.push_back(op);
				step_addr.push_back(addr);
				step_data.push_back(data);
				step_rexp.push_back(rexp);
				step_bexp.push_back(bexp);
			end
			$fclose(fd);
		end
		loaded = 1'b1;

		repeat (2) @(posedge MCLK);
		reset <= 1'b0;
		@(negedge MCLK);
		check_value("mbus_dtack_n", 16'(mbus_dtack_n), 16'h1);
		check_value("z80_dtack_n", 16'(z80_dtack_n), 16'h1);
		check_value("z80_busrq_n", 16'(z80_busrq_n), 16'h1);
		check_value("z80_reset_n", 16'(z80_reset_n), 16'h0);
		check_value("bank_addr", 16'(bank_addr), 16'h0);

		if (step_src.size() == 0) begin
			$display("the test data file holds no test steps");
			errors++;
		end

		for (int i = 0; i < step_src.size(); i++) begin
			gap = {$random(seed)} % 4;
			repeat (gap) @(posedge MCLK);
			case (step_src[i])
				"m": mbus_access(step_op[i], step_addr[i], step_data[i], step_rexp[i]);
				"z": z80_access(step_op[i], step_addr[i], step_data[i], step_rexp[i]);
				"b": both_access(step_op[i], step_addr[i], step_data[i], step_rexp[i]);
				"c": ctrl_write(step_addr[i], step_data[i], step_rexp[i]);
				default: begin
					$display("test step %0d has an unknown source", i);
					errors++;
				end
			endcase
			check_value("bank_addr", 16'(bank_addr), step_bexp[i]);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Ends a hung run after 40 cycles per step plus reset and margin
	initial begin
		wait (loaded);
		repeat (40 * step_src.size() + 100) @(posedge MCLK);
		$display("run timed out before all test steps finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verification/zbus_testdata.txt
// src op addr data rd_exp bank_exp, all values in hex, op r or w
// src m 68000, z Z80, b both, c control (addr selector, rd_exp busrq_n,reset_n)
z w 0100 3C 00 000
z w 0101 C3 00 000
m w 0100 A5 00 000
m r 0100 00 FF 000
m r 0101 00 FF 000
z r 0100 00 3C 000
c w 0000 01 00 000
m w 0101 99 00 000
z r 0101 00 C3 000
c w 0001 01 01 000
m w 0100 A5 00 000
m w 0101 5A 00 000
m r 0100 00 A5 000
m r 0101 00 5A 000
m r 2100 00 A5 000
m r 2101 00 5A 000
z w 1234 77 00 000
z r 1234 00 77 000
z r 4800 00 FF 000
z r 6010 00 FF 000
z w 6000 01 00 100
z w 6000 FE 00 080
z w 6000 03 00 140
z w 6000 81 00 1A0
z w 6000 00 00 0D0
z w 6000 40 00 068
z w 6000 FF 00 134
z w 6000 02 00 09A
z w 6000 55 00 14D
b w 0200 C3 C3 14D
z w 0201 E7 00 14D
b r 0201 00 E7 14D
